// File: exec.f
common/exec_pkg.sv
design/operand_select.sv
alu/alu.sv
design/branch_unit.sv
design/execute_preg.sv
design/execute_stage.sv
verif/tb_execute_stage.sv

// File: Makefile
# Verilator build and run of the execute stage testbench.

TOP := tb_execute_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f exec.f -o sim_$(TOP)

run: compile
	-./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Run failed, see sim.log"; \
		exit 1; \
	elif ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "Run ended without a result, see sim.log"; \
		exit 1; \
	else \
		echo "Run passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_execute_stage.sv
// Execute stage testbench with a reference model and directed and random instructions.
`timescale 1ns/100ps

module tb_execute_stage
    import exec_pkg::*;
();

    localparam int RESET_CYCLES   = 5;
    localparam int NUM_RANDOM     = 400;
    // Directed ALU, forwarding and branch vectors plus the closing bubbles.
    localparam int TEST_CYCLES    = RESET_CYCLES + 96 + 9 + 96 + NUM_RANDOM + 3;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                    i_clk = 1'b0;
    logic                    i_rst_n;
    exec_in_t                i_instr;
    fwd_sel_e                i_fwd_rs1;
    fwd_sel_e                i_fwd_rs2;
    fwd_sel_e                i_fwd_src;
    logic [XLEN-1:0]         i_wb_result;
    logic [XLEN-1:0]         i_mem_value;
    exec_out_t               o_ex_mem;
    logic                    o_pc_src;
    logic [XLEN-1:0]         o_pc_target;
    logic [REG_ADDR_W-1:0]   o_rs1_addr;
    logic [REG_ADDR_W-1:0]   o_rs2_addr;
    logic [REG_ADDR_W-1:0]   o_rd_addr;
    logic                    o_load_instr;

    // Model state for the instruction on the inputs and the one in the register.
    exec_out_t               exp_next = '0;
    exec_out_t               exp_reg  = '0;
    logic                    exp_pc_src    = 1'b0;
    logic [XLEN-1:0]         exp_pc_target = '0;
    logic [15:0]             exp_taps      = '0;
    logic                    armed         = 1'b0;
    int                      cycle_count   = 0;
    integer                  seed          = 84;

    // Operand sets for shifts by 63 and 31, a negative SLT and word overflow.
    logic [XLEN-1:0] alu_a [3] = '{64'hF0F0_0000_8000_0001, 64'hFFFF_FFFF_FFFF_FFFB,
                                   64'h0000_0000_7FFF_FFFF};
    logic [XLEN-1:0] alu_b [3] = '{64'd63, 64'd7, 64'd1};
    logic [XLEN-1:0] alu_i [3] = '{64'd31, 64'hFFFF_FFFF_FFFF_FFFD, 64'h0000_0000_8000_0000};
    // Equal, less, greater, and signed/unsigned disagreeing.
    logic [XLEN-1:0] br_a [4] = '{64'd5, 64'd3, 64'd9, 64'hFFFF_FFFF_FFFF_FFFF};
    logic [XLEN-1:0] br_b [4] = '{64'd5, 64'd9, 64'd3, 64'd1};

    execute_stage u_execute_stage (
        .i_clk        ( i_clk        ),
        .i_rst_n      ( i_rst_n      ),
        .i_instr      ( i_instr      ),
        .i_fwd_rs1    ( i_fwd_rs1    ),
        .i_fwd_rs2    ( i_fwd_rs2    ),
        .i_fwd_src    ( i_fwd_src    ),
        .i_wb_result  ( i_wb_result  ),
        .i_mem_value  ( i_mem_value  ),
        .o_ex_mem     ( o_ex_mem     ),
        .o_pc_src     ( o_pc_src     ),
        .o_pc_target  ( o_pc_target  ),
        .o_rs1_addr   ( o_rs1_addr   ),
        .o_rs2_addr   ( o_rs2_addr   ),
        .o_rd_addr    ( o_rd_addr    ),
        .o_load_instr ( o_load_instr )
    );

    always #50 i_clk = ~i_clk;

    // ------------------------------------------------------------------------
    // Reporting.
    // ------------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on failure");
    endtask

    task automatic value_error(input string name, input logic [XLEN-1:0] exp_val,
                               input logic [XLEN-1:0] act_val);
        $display("Error: time %0t, %s expected 0x%0h, actual 0x%0h",
                 $time, name, exp_val, act_val);
        fail_run("A checked output did not match the reference model.");
    endtask

    // ------------------------------------------------------------------------
    // Reference model.
    // ------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [XLEN-1:0] fwd_value(input logic [1:0] sel,
        input logic [XLEN-1:0] reg_data, input logic [XLEN-1:0] wb,
        input logic [XLEN-1:0] mem);
        case (sel)
            FWD_WB:  return wb;
            FWD_MEM: return mem;
            default: return reg_data;
        endcase
    endfunction

    // Signed less-than from the sign bits and then the magnitude.
    function automatic logic less_signed(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input logic [4:0] op,
        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [31:0]     w;
        logic [XLEN-1:0] res;
        logic            is_word;
        w       = '0;
        res     = '0;
        is_word = 1'b1;
        case (op)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_AND:    res = a & b;
            ALU_OR:     res = a | b;
            ALU_XOR:    res = a ^ b;
            ALU_SLL:    res = a << b[5:0];
            ALU_SRL:    res = a >> b[5:0];
            ALU_SRA:    res = (a >> b[5:0]) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> b[5:0]) : '0);
            ALU_SLT:    res = {63'd0, less_signed(a, b)};
            ALU_SLTU:   res = {63'd0, a < b};
            ALU_ADDW:   w = a[31:0] + b[31:0];
            ALU_SUBW:   w = a[31:0] - b[31:0];
            ALU_SLLW:   w = a[31:0] << b[4:0];
            ALU_SRLW:   w = a[31:0] >> b[4:0];
            ALU_SRAW:   w = (a[31:0] >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            ALU_PASS_B: res = b;
            default:    res = '0;
        endcase
        case (op)
            ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW: is_word = 1'b1;
            default: is_word = 1'b0;
        endcase
        if (is_word) begin
            res = {{32{w[31]}}, w};
        end
        return res;
    endfunction

    function automatic logic cond_model(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return less_signed(a, b);
            3'd5:    return !less_signed(a, b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [12:0] ctrl_bits(input exec_out_t x);
        return {x.result_src, x.mem_we, x.reg_we, x.load_instr, x.rd_addr, x.fwd_src};
    endfunction

    // ------------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------------
    task automatic check_comb();
        assert (o_pc_src == exp_pc_src)
            else value_error("o_pc_src", XLEN'(exp_pc_src), XLEN'(o_pc_src));
        assert (o_pc_target == exp_pc_target)
            else value_error("o_pc_target", exp_pc_target, o_pc_target);
        assert ({o_rs1_addr, o_rs2_addr, o_rd_addr, o_load_instr} == exp_taps)
            else value_error("o_rs1_addr/o_rs2_addr/o_rd_addr/o_load_instr", XLEN'(exp_taps),
                             XLEN'({o_rs1_addr, o_rs2_addr, o_rd_addr, o_load_instr}));
    endtask

    // Register model that clears in reset like the EX/MEM register.
    always @(posedge i_clk) begin
        armed <= 1'b1;
        if (!i_rst_n) begin
            exp_reg <= '0;
        end else begin
            exp_reg <= exp_next;
        end
    end

    a_alu_result: assert property (@(posedge i_clk)
        !armed || o_ex_mem.alu_result == exp_reg.alu_result)
        else value_error("o_ex_mem.alu_result", $sampled(exp_reg.alu_result),
                         $sampled(o_ex_mem.alu_result));
    a_write_data: assert property (@(posedge i_clk)
        !armed || o_ex_mem.write_data == exp_reg.write_data)
        else value_error("o_ex_mem.write_data", $sampled(exp_reg.write_data),
                         $sampled(o_ex_mem.write_data));
    a_pc_target: assert property (@(posedge i_clk)
        !armed || o_ex_mem.pc_target == exp_reg.pc_target)
        else value_error("o_ex_mem.pc_target", $sampled(exp_reg.pc_target),
                         $sampled(o_ex_mem.pc_target));
    a_pc_plus4: assert property (@(posedge i_clk)
        !armed || o_ex_mem.pc_plus4 == exp_reg.pc_plus4)
        else value_error("o_ex_mem.pc_plus4", $sampled(exp_reg.pc_plus4),
                         $sampled(o_ex_mem.pc_plus4));
    a_imm_ext: assert property (@(posedge i_clk)
        !armed || o_ex_mem.imm_ext == exp_reg.imm_ext)
        else value_error("o_ex_mem.imm_ext", $sampled(exp_reg.imm_ext),
                         $sampled(o_ex_mem.imm_ext));
    // Result_src, mem_we, reg_we, load_instr, rd_addr and fwd_src together.
    a_control: assert property (@(posedge i_clk)
        !armed || ctrl_bits(o_ex_mem) == ctrl_bits(exp_reg))
        else value_error("o_ex_mem control", XLEN'(ctrl_bits($sampled(exp_reg))),
                         XLEN'(ctrl_bits($sampled(o_ex_mem))));

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the test sequence did not finish in the expected cycles.");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------------
    // Checks the previous inputs' combinational outputs and then drives the next ones.
    task automatic drive_cycle(
        input exec_in_t        ins,
        input logic [1:0]      f1,
        input logic [1:0]      f2,
        input logic [1:0]      fs,
        input logic [XLEN-1:0] wb,
        input logic [XLEN-1:0] mem,
        input logic            rst_n
    );
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] rs2v;
        logic [XLEN-1:0] b;
        @(negedge i_clk);
        check_comb();
        i_rst_n     = rst_n;
        i_instr     = ins;
        i_fwd_rs1   = fwd_sel_e'(f1);
        i_fwd_rs2   = fwd_sel_e'(f2);
        i_fwd_src   = fwd_sel_e'(fs);
        i_wb_result = wb;
        i_mem_value = mem;
        a    = fwd_value(f1, ins.rs1_data, wb, mem);
        rs2v = fwd_value(f2, ins.rs2_data, wb, mem);
        b    = ins.alu_src ? ins.imm_ext : rs2v;
        exp_pc_target = ins.pc + ins.imm_ext;
        exp_pc_src    = ins.jump | (ins.branch & cond_model(ins.br_cond, a, rs2v));
        exp_taps      = {ins.rs1_addr, ins.rs2_addr, ins.rd_addr, ins.load_instr};
        exp_next.result_src = ins.result_src;
        exp_next.mem_we     = ins.mem_we;
        exp_next.reg_we     = ins.reg_we;
        exp_next.load_instr = ins.load_instr;
        exp_next.pc_plus4   = ins.pc_plus4;
        exp_next.pc_target  = exp_pc_target;
        exp_next.imm_ext    = ins.imm_ext;
        exp_next.alu_result = alu_model(ins.alu_op, a, b);
        exp_next.write_data = rs2v;
        exp_next.rd_addr    = ins.rd_addr;
        exp_next.fwd_src    = fwd_sel_e'(fs);
    endtask

    initial begin
        exec_in_t    ins;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        i_rst_n     = 1'b0;
        i_instr     = '0;
        i_fwd_rs1   = FWD_REG;
        i_fwd_rs2   = FWD_REG;
        i_fwd_src   = FWD_REG;
        i_wb_result = '0;
        i_mem_value = '0;

        // Reset cycles carry a live instruction that the register must drop.
        ins            = '0;
        ins.pc         = 64'h0000_0000_0000_0100;
        ins.pc_plus4   = 64'h0000_0000_0000_0104;
        ins.rs1_data   = 64'h0000_0000_0000_0055;
        ins.rs2_data   = 64'h0000_0000_0000_00AA;
        ins.imm_ext    = 64'h0000_0000_0000_0010;
        ins.rd_addr    = 5'd7;
        ins.alu_op     = ALU_ADD;
        ins.result_src = RES_MEM;
        ins.mem_we     = 1'b1;
        ins.reg_we     = 1'b1;
        ins.load_instr = 1'b1;

        // The first reset cycle comes from the initial values.
        repeat (RESET_CYCLES - 1) begin
            drive_cycle(ins, FWD_WB, FWD_MEM, FWD_MEM, 64'h33, 64'h44, 1'b0);
        end

        // Every ALU operation on each operand set, register and immediate B.
        for (int s = 0; s < 3; s++) begin
            for (int op = 0; op < 16; op++) begin
                for (int src = 0; src < 2; src++) begin
                    ins          = '0;
                    ins.rs1_data = alu_a[s];
                    ins.rs2_data = alu_b[s];
                    ins.imm_ext  = alu_i[s];
                    ins.alu_op   = alu_op_e'(op[4:0]);
                    ins.alu_src  = src[0];
                    ins.reg_we   = 1'b1;
                    ins.rd_addr  = op[4:0];
                    drive_cycle(ins, FWD_REG, FWD_REG, FWD_REG, '0, '0, 1'b1);
                end
            end
        end

        // All forwarding source pairs.
        for (int f1 = 0; f1 < 3; f1++) begin
            for (int f2 = 0; f2 < 3; f2++) begin
                ins          = '0;
                ins.rs1_data = 64'h0000_0000_0000_1111;
                ins.rs2_data = 64'h0000_0000_2222_0000;
                ins.mem_we   = 1'b1;
                ins.rs1_addr = 5'(f1 + 1);
                ins.rs2_addr = 5'(f2 + 4);
                drive_cycle(ins, f1[1:0], f2[1:0], f1[1:0], 64'h0003_0000_0000_0000,
                            64'h0400_0000_0000_0000, 1'b1);
            end
        end

        // Each funct3, including 2 and 3, with branch only, branch and jump, jump only.
        for (int c = 0; c < 8; c++) begin
            for (int p = 0; p < 4; p++) begin
                for (int k = 0; k < 3; k++) begin
                    ins            = '0;
                    ins.pc         = 64'h8000_0000 + 64'(c * 64 + p * 16 + k * 4);
                    ins.pc_plus4   = ins.pc + 64'd4;
                    ins.imm_ext    = (k == 1) ? 64'hFFFF_FFFF_FFFF_FF00 : 64'h800;
                    ins.rs1_data   = br_a[p];
                    ins.rs2_data   = br_b[p];
                    ins.br_cond    = branch_cond_e'(c[2:0]);
                    ins.branch     = (k < 2);
                    ins.jump       = (k > 0);
                    ins.result_src = RES_TARGET;
                    drive_cycle(ins, FWD_REG, FWD_REG, FWD_REG, '0, '0, 1'b1);
                end
            end
        end

        // Back-to-back random instructions.
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd            = $random(seed);
            rnd2           = $random(seed);
            ins.pc         = rand64();
            ins.pc_plus4   = ins.pc + 64'd4;
            ins.rs1_data   = rand64();
            ins.rs2_data   = (rnd[31:30] == 2'b00) ? ins.rs1_data : rand64();
            ins.imm_ext    = rand64();
            ins.rs1_addr   = rnd[4:0];
            ins.rs2_addr   = rnd[9:5];
            ins.rd_addr    = rnd[14:10];
            ins.alu_op     = alu_op_e'({1'b0, rnd[18:15]});
            ins.br_cond    = branch_cond_e'(rnd[21:19]);
            ins.result_src = result_src_e'(rnd[24:22] % 3'd5);
            ins.alu_src    = rnd[25];
            ins.mem_we     = rnd[26];
            ins.reg_we     = rnd[27];
            ins.branch     = rnd[28];
            ins.jump       = rnd[29];
            ins.load_instr = rnd2[6];
            drive_cycle(ins, rnd2[1:0], rnd2[3:2], rnd2[5:4], rand64(), rand64(), 1'b1);
        end

        // Bubbles flush the last instruction through the register.
        drive_cycle('0, FWD_REG, FWD_REG, FWD_REG, '0, '0, 1'b1);
        drive_cycle('0, FWD_REG, FWD_REG, FWD_REG, '0, '0, 1'b1);
        @(negedge i_clk);
        check_comb();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: design/execute_stage.sv
// Execute stage top: operand selection, ALU, branch unit and EX/MEM register.
`timescale 1ns/100ps

module execute_stage
    import exec_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  exec_in_t                  i_instr,
    input  fwd_sel_e                  i_fwd_rs1,
    input  fwd_sel_e                  i_fwd_rs2,
    input  fwd_sel_e                  i_fwd_src,
    input  logic [ XLEN       - 1:0 ] i_wb_result,
    input  logic [ XLEN       - 1:0 ] i_mem_value,

    output exec_out_t                 o_ex_mem,
    output logic                      o_pc_src,
    output logic [ XLEN       - 1:0 ] o_pc_target,
    output logic [ REG_ADDR_W - 1:0 ] o_rs1_addr,
    output logic [ REG_ADDR_W - 1:0 ] o_rs2_addr,
    output logic [ REG_ADDR_W - 1:0 ] o_rd_addr,
    output logic                      o_load_instr
);

    // ------------------------------------------------------------------------
    // Internal nets.
    // ------------------------------------------------------------------------
    logic [ XLEN - 1:0 ] s_src_a;
    logic [ XLEN - 1:0 ] s_src_b;
    logic [ XLEN - 1:0 ] s_write_data;
    logic [ XLEN - 1:0 ] s_alu_result;

    // ------------------------------------------------------------------------
    // Datapath.
    // ------------------------------------------------------------------------
    operand_select u_operand_select (
        .i_rs1_data   ( i_instr.rs1_data ),
        .i_rs2_data   ( i_instr.rs2_data ),
        .i_imm_ext    ( i_instr.imm_ext  ),
        .i_wb_result  ( i_wb_result      ),
        .i_mem_value  ( i_mem_value      ),
        .i_fwd_rs1    ( i_fwd_rs1        ),
        .i_fwd_rs2    ( i_fwd_rs2        ),
        .i_alu_src    ( i_instr.alu_src  ),
        .o_src_a      ( s_src_a          ),
        .o_src_b      ( s_src_b          ),
        .o_write_data ( s_write_data     )
    );

    alu u_alu (
        .i_alu_op ( i_instr.alu_op ),
        .i_src_a  ( s_src_a        ),
        .i_src_b  ( s_src_b        ),
        .o_result ( s_alu_result   )
    );

    // Compares forwarded rs1/rs2, not the ALU operands.
    branch_unit u_branch_unit (
        .i_pc        ( i_instr.pc      ),
        .i_imm_ext   ( i_instr.imm_ext ),
        .i_rs1       ( s_src_a         ),
        .i_rs2       ( s_write_data    ),
        .i_br_cond   ( i_instr.br_cond ),
        .i_branch    ( i_instr.branch  ),
        .i_jump      ( i_instr.jump    ),
        .o_pc_src    ( o_pc_src        ),
        .o_pc_target ( o_pc_target     )
    );

    execute_preg u_execute_preg (
        .i_clk        ( i_clk        ),
        .i_rst_n      ( i_rst_n      ),
        .i_instr      ( i_instr      ),
        .i_alu_result ( s_alu_result ),
        .i_pc_target  ( o_pc_target  ),
        .i_write_data ( s_write_data ),
        .i_fwd_src    ( i_fwd_src    ),
        .o_ex_mem     ( o_ex_mem     )
    );

    // Hazard unit taps.
    assign o_rs1_addr   = i_instr.rs1_addr;
    assign o_rs2_addr   = i_instr.rs2_addr;
    assign o_rd_addr    = i_instr.rd_addr;
    assign o_load_instr = i_instr.load_instr;

endmodule

// File: design/execute_preg.sv
// Execute/memory pipeline register merging ALU, branch and control results.
`timescale 1ns/100ps

module execute_preg
    import exec_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  exec_in_t            i_instr,
    input  logic [ XLEN - 1:0 ] i_alu_result,
    input  logic [ XLEN - 1:0 ] i_pc_target,
    input  logic [ XLEN - 1:0 ] i_write_data,
    input  fwd_sel_e            i_fwd_src,

    output exec_out_t           o_ex_mem
);

    exec_out_t s_next;

    // ------------------------------------------------------------------------
    // Next register contents.
    // ------------------------------------------------------------------------
    always_comb begin
        // Control carried to memory and writeback.
        s_next.result_src = i_instr.result_src;
        s_next.mem_we     = i_instr.mem_we;
        s_next.reg_we     = i_instr.reg_we;
        s_next.load_instr = i_instr.load_instr;

        // Datapath results.
        s_next.pc_plus4   = i_instr.pc_plus4;
        s_next.pc_target  = i_pc_target;
        s_next.imm_ext    = i_instr.imm_ext;
        s_next.alu_result = i_alu_result;
        s_next.write_data = i_write_data;

        s_next.rd_addr    = i_instr.rd_addr;
        s_next.fwd_src    = i_fwd_src;
    end

    // ------------------------------------------------------------------------
    // Register.
    // ------------------------------------------------------------------------
    // All zeros on reset gives a bubble with RES_ALU.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem <= s_next;
        end
    end

endmodule

// File: design/branch_unit.sv
// Branch unit: condition compare, taken decision and PC-relative target.
`timescale 1ns/100ps

module branch_unit
    import exec_pkg::*;
(
    input  logic [ XLEN - 1:0 ] i_pc,
    input  logic [ XLEN - 1:0 ] i_imm_ext,
    input  logic [ XLEN - 1:0 ] i_rs1,
    input  logic [ XLEN - 1:0 ] i_rs2,
    input  branch_cond_e        i_br_cond,
    input  logic                i_branch,
    input  logic                i_jump,

    output logic                o_pc_src,
    output logic [ XLEN - 1:0 ] o_pc_target
);

    // ------------------------------------------------------------------------
    // Compare flags.
    // ------------------------------------------------------------------------
    logic s_eq;
    logic s_lt;
    logic s_ltu;
    logic s_cond;
    logic s_taken;

    assign s_eq  = (i_rs1 == i_rs2);
    assign s_lt  = ($signed(i_rs1) < $signed(i_rs2));
    assign s_ltu = (i_rs1 < i_rs2);

    // ------------------------------------------------------------------------
    // Condition select.
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_br_cond)
            BR_EQ:   s_cond = s_eq;
            BR_NE:   s_cond = ~s_eq;
            BR_LT:   s_cond = s_lt;
            BR_GE:   s_cond = ~s_lt;
            BR_LTU:  s_cond = s_ltu;
            BR_GEU:  s_cond = ~s_ltu;
            // Funct3 2 and 3 are not branches.
            default: s_cond = 1'b0;
        endcase
    end

    assign s_taken = i_branch & s_cond;

    // Redirect fetch on a jump or a taken branch.
    assign o_pc_src = i_jump | s_taken;

    // Shared target for branches and jal.
    assign o_pc_target = i_pc + i_imm_ext;

endmodule

// File: alu/alu.sv
// RV64 integer ALU with full-width and 32-bit word operations.
`timescale 1ns/100ps

module alu
    import exec_pkg::*;
(
    input  alu_op_e             i_alu_op,
    input  logic [ XLEN - 1:0 ] i_src_a,
    input  logic [ XLEN - 1:0 ] i_src_b,

    output logic [ XLEN - 1:0 ] o_result
);

    // ------------------------------------------------------------------------
    // Operand slices.
    // ------------------------------------------------------------------------
    logic [ SHAMT_W  - 1:0 ] s_shamt;
    logic [ WSHAMT_W - 1:0 ] s_shamt_w;
    logic [ WORD_W   - 1:0 ] s_a_lo;
    logic [ WORD_W   - 1:0 ] s_b_lo;

    logic [ XLEN   - 1:0 ] s_full_res;
    logic [ WORD_W - 1:0 ] s_word_res;
    logic                  s_is_word;

    assign s_shamt   = i_src_b[SHAMT_W-1:0];
    assign s_shamt_w = i_src_b[WSHAMT_W-1:0];
    assign s_a_lo    = i_src_a[WORD_W-1:0];
    assign s_b_lo    = i_src_b[WORD_W-1:0];

    // ------------------------------------------------------------------------
    // Operation select.
    // ------------------------------------------------------------------------
    always_comb begin
        s_full_res = '0;
        s_word_res = '0;
        s_is_word  = 1'b0;
        case (i_alu_op)
            ALU_ADD:    s_full_res = i_src_a + i_src_b;
            ALU_SUB:    s_full_res = i_src_a - i_src_b;
            ALU_AND:    s_full_res = i_src_a & i_src_b;
            ALU_OR:     s_full_res = i_src_a | i_src_b;
            ALU_XOR:    s_full_res = i_src_a ^ i_src_b;
            ALU_SLL:    s_full_res = i_src_a << s_shamt;
            ALU_SRL:    s_full_res = i_src_a >> s_shamt;
            ALU_SRA:    s_full_res = $signed(i_src_a) >>> s_shamt;
            ALU_SLT: begin
                s_full_res = {{(XLEN-1){1'b0}}, $signed(i_src_a) < $signed(i_src_b)};
            end
            ALU_SLTU: begin
                s_full_res = {{(XLEN-1){1'b0}}, i_src_a < i_src_b};
            end
            // Word forms work on the low half only.
            ALU_ADDW: begin
                s_is_word  = 1'b1;
                s_word_res = s_a_lo + s_b_lo;
            end
            ALU_SUBW: begin
                s_is_word  = 1'b1;
                s_word_res = s_a_lo - s_b_lo;
            end
            ALU_SLLW: begin
                s_is_word  = 1'b1;
                s_word_res = s_a_lo << s_shamt_w;
            end
            ALU_SRLW: begin
                s_is_word  = 1'b1;
                s_word_res = s_a_lo >> s_shamt_w;
            end
            ALU_SRAW: begin
                s_is_word  = 1'b1;
                s_word_res = $signed(s_a_lo) >>> s_shamt_w;
            end
            ALU_PASS_B: s_full_res = i_src_b;  // lui
            default:    s_full_res = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Result.
    // ------------------------------------------------------------------------
    // Word results are sign-extended from bit 31.
    assign o_result = s_is_word
                    ? {{(XLEN-WORD_W){s_word_res[WORD_W-1]}}, s_word_res}
                    : s_full_res;

endmodule

// File: design/operand_select.sv
// Operand selector: rs1/rs2 forwarding muxes and the ALU second operand choice.
`timescale 1ns/100ps

module operand_select
    import exec_pkg::*;
(
    input  logic [ XLEN - 1:0 ] i_rs1_data,
    input  logic [ XLEN - 1:0 ] i_rs2_data,
    input  logic [ XLEN - 1:0 ] i_imm_ext,
    input  logic [ XLEN - 1:0 ] i_wb_result,
    input  logic [ XLEN - 1:0 ] i_mem_value,
    input  fwd_sel_e            i_fwd_rs1,
    input  fwd_sel_e            i_fwd_rs2,
    input  logic                i_alu_src,

    output logic [ XLEN - 1:0 ] o_src_a,
    output logic [ XLEN - 1:0 ] o_src_b,
    output logic [ XLEN - 1:0 ] o_write_data
);

    // 3:1 forwarding mux, unused code falls back to register data.
    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_data,
        input logic [XLEN-1:0] wb_data,
        input logic [XLEN-1:0] mem_data
    );
        logic [XLEN-1:0] res;
        case (sel)
            FWD_WB:  res = wb_data;
            FWD_MEM: res = mem_data;
            default: res = reg_data;
        endcase
        return res;
    endfunction

    logic [ XLEN - 1:0 ] s_fwd_rs2;

    // ------------------------------------------------------------------------
    // Forwarding.
    // ------------------------------------------------------------------------
    assign o_src_a   = fwd_mux(i_fwd_rs1, i_rs1_data, i_wb_result, i_mem_value);
    assign s_fwd_rs2 = fwd_mux(i_fwd_rs2, i_rs2_data, i_wb_result, i_mem_value);

    // Store data is always the forwarded rs2.
    assign o_write_data = s_fwd_rs2;

    // Immediate or register for operand B.
    assign o_src_b = i_alu_src ? i_imm_ext : s_fwd_rs2;

endmodule

// File: common/exec_pkg.sv
// Execute stage shared widths, operation encodings and pipeline bundles.

package exec_pkg;

    // ------------------------------------------------------------------------
    // Widths.
    // ------------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int WORD_W     = 32;
    // Shift amount widths for full and word shifts.
    localparam int SHAMT_W    = 6;
    localparam int WSHAMT_W   = 5;

    // ------------------------------------------------------------------------
    // Encodings.
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_SLL    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_SLT    = 5'd8,
        ALU_SLTU   = 5'd9,
        ALU_ADDW   = 5'd10,
        ALU_SUBW   = 5'd11,
        ALU_SLLW   = 5'd12,
        ALU_SRLW   = 5'd13,
        ALU_SRAW   = 5'd14,
        ALU_PASS_B = 5'd15
    } alu_op_e;

    // Same values as the branch funct3.
    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd4,
        BR_GE  = 3'd5,
        BR_LTU = 3'd6,
        BR_GEU = 3'd7
    } branch_cond_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    typedef enum logic [2:0] {
        RES_ALU    = 3'd0,
        RES_MEM    = 3'd1,
        RES_PC4    = 3'd2,
        RES_IMM    = 3'd3,
        RES_TARGET = 3'd4
    } result_src_e;

    // ------------------------------------------------------------------------
    // Pipeline bundles.
    // ------------------------------------------------------------------------
    // Decoded instruction entering execute.
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm_ext;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [REG_ADDR_W-1:0] rd_addr;
        alu_op_e               alu_op;
        branch_cond_e          br_cond;
        result_src_e           result_src;
        logic                  alu_src;
        logic                  mem_we;
        logic                  reg_we;
        logic                  branch;
        logic                  jump;
        logic                  load_instr;
    } exec_in_t;

    // Execute/memory register contents.
    typedef struct packed {
        result_src_e           result_src;
        logic                  mem_we;
        logic                  reg_we;
        logic                  load_instr;
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       pc_target;
        logic [XLEN-1:0]       imm_ext;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       write_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        fwd_sel_e              fwd_src;
    } exec_out_t;

endpackage
